// File: src/mem_pkg.sv
// mem_pkg
// Shared widths, request and bank command types and the write
// sequencer states for the dual-port instruction/data memory.
// Port A fetches a 128-bit line, port B reads and writes 32-bit words.

package mem_pkg;

  localparam int ADDR_W    = 8;    // word address, both ports
  localparam int WORD_W    = 32;   // data word
  localparam int NUM_LANES = 4;    // words per line = banks
  localparam int ROW_W     = 6;    // bank row address
  localparam int LINE_W    = 128;  // fetch line, NUM_LANES words

  // fetch port request, read only
  typedef struct packed {
    logic              en;    // fetch strobe
    logic [ADDR_W-1:0] addr;  // word offset, lane bits ignored
  } fetch_req_t;

  // data port request
  typedef struct packed {
    logic                  en;     // access strobe
    logic                  we;     // 1 = masked write
    logic [WORD_W/8-1:0]   be;     // byte enables, bit 0 = low byte
    logic [ADDR_W-1:0]     addr;   // word address
    logic [WORD_W-1:0]     wdata;  // write data
  } data_req_t;

  // per-bank command from the router
  // port A and port B carry their own row so fetches and data
  // accesses to different rows run in the same cycle
  typedef struct packed {
    logic              a_en;   // port A read
    logic [ROW_W-1:0]  a_row;  // port A row
    logic              b_en;   // port B access
    logic              b_we;   // port B whole-word write
    logic [ROW_W-1:0]  b_row;  // port B row
    logic [WORD_W-1:0] wdata;  // port B write word, already merged
  } bank_cmd_t;

  // byte-masked write sequencer
  typedef enum logic [0:0] {
    WR_IDLE  = 1'b0,  // accepting data requests
    WR_MERGE = 1'b1   // old word on the bus, merged write goes out
  } rmw_state_e;

endpackage

// File: src/ram_bank.sv
// ram_bank
// One 32-bit x 64-entry true dual-port bank, inferred as block RAM.
// Port A reads only, port B reads or writes whole words.
// Both read ports are registered, read-first, one cycle of latency.

`timescale 1ns/1ps

module ram_bank (
  input  logic                        clk_i,
  input  mem_pkg::bank_cmd_t          cmd_i,
  output logic [mem_pkg::WORD_W-1:0]  a_rdata_o,
  output logic [mem_pkg::WORD_W-1:0]  b_rdata_o
);

  // storage, contents are not reset
  logic [mem_pkg::WORD_W-1:0] mem_q [2**mem_pkg::ROW_W];

  // port A, fetch side
  always_ff @(posedge clk_i) begin
    if (cmd_i.a_en) begin
      a_rdata_o <= mem_q[cmd_i.a_row];  // old data on a same-edge write
    end
  end

  // port B, data side
  always_ff @(posedge clk_i) begin
    if (cmd_i.b_en) begin
      b_rdata_o <= mem_q[cmd_i.b_row];  // read-first
      if (cmd_i.b_we) begin
        mem_q[cmd_i.b_row] <= cmd_i.wdata;
      end
    end
  end

  // router must never issue a write without the port enable
  b_we_needs_en_a : assert property (
    @(posedge clk_i) cmd_i.b_we |-> cmd_i.b_en
  ) else $error("ram_bank: b_we without b_en");

endmodule

// File: src/bank_router.sv
// bank_router
// Splits fetch and data addresses into row and lane, broadcasts the fetch
// to all banks and steers data requests to one bank.
// A data write is read-modify-write over two cycles: read the old word,
// then write back the byte-merged word. busy_o covers the second cycle.

`timescale 1ns/1ps

module bank_router (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  mem_pkg::fetch_req_t          fetch_i,
  input  mem_pkg::data_req_t           data_i,
  input  logic [mem_pkg::WORD_W-1:0]   old_word_i,  // port B word of lane_o
  output mem_pkg::bank_cmd_t           cmd_o [mem_pkg::NUM_LANES],
  output logic [1:0]                   lane_o,
  output logic                         busy_o
);

  mem_pkg::rmw_state_e            state_q;
  logic [1:0]                     lane_q;     // lane of last accepted data request
  logic [mem_pkg::ROW_W-1:0]      row_q;      // captured write row
  logic [mem_pkg::WORD_W/8-1:0]   be_q;       // captured byte enables
  logic [mem_pkg::WORD_W-1:0]     wdata_q;    // captured write data
  logic [mem_pkg::WORD_W-1:0]     merged;     // new bytes over old word
  logic [1:0]                     data_lane;
  logic [mem_pkg::ROW_W-1:0]      data_row;
  logic                           data_acc;   // data request taken this cycle
  logic                           wr_acc;
  logic                           any_b_we;

  // address split, lane = addr mod 4, row = addr / 4
  assign data_lane = data_i.addr[mem_pkg::ADDR_W-mem_pkg::ROW_W-1:0];
  assign data_row  = data_i.addr[mem_pkg::ADDR_W-1 -: mem_pkg::ROW_W];

  assign data_acc = data_i.en && (state_q == mem_pkg::WR_IDLE);  // dropped while busy
  assign wr_acc   = data_acc && data_i.we;
  assign busy_o   = (state_q == mem_pkg::WR_MERGE);
  assign lane_o   = lane_q;

  // byte merge, enabled bytes from wdata, the rest from the old word
  always_comb begin
    for (int b = 0; b < mem_pkg::WORD_W/8; b++) begin
      merged[b*8 +: 8] = be_q[b] ? wdata_q[b*8 +: 8] : old_word_i[b*8 +: 8];
    end
  end

  // per-bank commands
  always_comb begin
    for (int i = 0; i < mem_pkg::NUM_LANES; i++) begin
      cmd_o[i].a_en  = fetch_i.en;  // fetch hits every bank at one row
      cmd_o[i].a_row = fetch_i.addr[mem_pkg::ADDR_W-1 -: mem_pkg::ROW_W];
      cmd_o[i].b_en  = 1'b0;
      cmd_o[i].b_we  = 1'b0;
      cmd_o[i].b_row = data_row;
      cmd_o[i].wdata = merged;
    end
    if (state_q == mem_pkg::WR_MERGE) begin
      // second cycle of a write, merged word goes back to the same row
      cmd_o[lane_q].b_en  = 1'b1;
      cmd_o[lane_q].b_we  = 1'b1;
      cmd_o[lane_q].b_row = row_q;
    end else if (data_i.en) begin
      cmd_o[data_lane].b_en = 1'b1;  // read, also the first half of a write
    end
  end

  // sequencer and lane register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= mem_pkg::WR_IDLE;
      lane_q  <= '0;
    end else begin
      if (data_acc) begin
        lane_q <= data_lane;  // selects the port B word one cycle later
      end
      case (state_q)
        mem_pkg::WR_IDLE:  if (wr_acc) state_q <= mem_pkg::WR_MERGE;
        mem_pkg::WR_MERGE: state_q <= mem_pkg::WR_IDLE;  // always one cycle
        default:           state_q <= mem_pkg::WR_IDLE;
      endcase
    end
  end

  // write payload, held for the merge cycle
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      row_q   <= data_row;
      be_q    <= data_i.be;
      wdata_q <= data_i.wdata;
    end
  end

  always_comb begin
    any_b_we = 1'b0;
    for (int i = 0; i < mem_pkg::NUM_LANES; i++) begin
      any_b_we = any_b_we | cmd_o[i].b_we;
    end
  end

  // accepted write gives exactly one busy cycle
  busy_one_cycle_a : assert property (
    @(posedge clk_i) disable iff (rst_i) wr_acc |=> busy_o ##1 !busy_o
  ) else $error("bank_router: busy_o not a single cycle after write");

  // bank writes only come out of the merge state
  no_we_in_idle_a : assert property (
    @(posedge clk_i) disable iff (rst_i) (state_q == mem_pkg::WR_IDLE) |-> !any_b_we
  ) else $error("bank_router: bank write in WR_IDLE");

endmodule

// File: src/line_collector.sv
// line_collector
// Builds the fetch line from the four port A words, lane 0 lowest, and
// picks the data port word by the registered lane. Both outputs are
// registered once more; the selected word also goes back to the router
// without a register for the write merge.

`timescale 1ns/1ps

module line_collector (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [mem_pkg::WORD_W-1:0]  a_rdata_i [mem_pkg::NUM_LANES],
  input  logic [mem_pkg::WORD_W-1:0]  b_rdata_i [mem_pkg::NUM_LANES],
  input  logic [1:0]                  lane_i,
  output logic [mem_pkg::LINE_W-1:0]  line_o,
  output logic [mem_pkg::WORD_W-1:0]  rdata_o,
  output logic [mem_pkg::WORD_W-1:0]  old_word_o
);

  logic [mem_pkg::LINE_W-1:0] line_d;
  logic [mem_pkg::WORD_W-1:0] word_sel;  // port B word of the current lane

  always_comb begin
    for (int i = 0; i < mem_pkg::NUM_LANES; i++) begin
      line_d[i*mem_pkg::WORD_W +: mem_pkg::WORD_W] = a_rdata_i[i];  // lane i, word i
    end
  end

  assign word_sel   = b_rdata_i[lane_i];
  assign old_word_o = word_sel;  // used in the WR_MERGE cycle

  // bank outputs hold between accesses, so copying every cycle keeps
  // line_o stable until the next fetch
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      line_o  <= '0;
      rdata_o <= '0;
    end else begin
      line_o  <= line_d;
      rdata_o <= word_sel;
    end
  end

endmodule

// File: src/dp_ram_top.sv
// dp_ram_top
// Dual-port instruction/data memory: 256 words in four 64-entry banks.
// Fetch port returns a 128-bit line, data port reads and writes words
// with byte enables. Router, bank array and collector, wiring only.

`timescale 1ns/1ps

module dp_ram_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  mem_pkg::fetch_req_t         fetch_i,
  input  mem_pkg::data_req_t          data_i,
  output logic [mem_pkg::LINE_W-1:0]  line_o,
  output logic [mem_pkg::WORD_W-1:0]  rdata_o,
  output logic                        busy_o
);

  mem_pkg::bank_cmd_t          bank_cmd [mem_pkg::NUM_LANES];  // one per bank
  logic [mem_pkg::WORD_W-1:0]  a_rdata  [mem_pkg::NUM_LANES];
  logic [mem_pkg::WORD_W-1:0]  b_rdata  [mem_pkg::NUM_LANES];
  logic [mem_pkg::WORD_W-1:0]  old_word;  // merge source for writes
  logic [1:0]                  lane;

  bank_router bank_router_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fetch_i    (fetch_i),
    .data_i     (data_i),
    .old_word_i (old_word),
    .cmd_o      (bank_cmd),
    .lane_o     (lane),
    .busy_o     (busy_o)
  );

  // one bank per word lane, one row = one fetch line
  for (genvar i = 0; i < mem_pkg::NUM_LANES; i++) begin : gen_bank
    ram_bank ram_bank_inst (
      .clk_i     (clk_i),
      .cmd_i     (bank_cmd[i]),
      .a_rdata_o (a_rdata[i]),
      .b_rdata_o (b_rdata[i])
    );
  end

  line_collector line_collector_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .a_rdata_i  (a_rdata),
    .b_rdata_i  (b_rdata),
    .lane_i     (lane),
    .line_o     (line_o),
    .rdata_o    (rdata_o),
    .old_word_o (old_word)
  );

endmodule

// File: test/dp_ram_checks.svh
// dp_ram_checks
// Typed compare tasks and error counters for the dual-port memory testbench.
// Included inside the testbench module body.

`ifndef DP_RAM_CHECKS_SVH
`define DP_RAM_CHECKS_SVH

  int word_errors  = 0;  // rdata_o mismatches
  int line_errors  = 0;  // line_o mismatches
  int busy_errors  = 0;  // busy_o mismatches
  int other_errors = 0;  // timeouts, case file trouble

  // data port word
  task automatic check_word(input string name,
                            input logic [mem_pkg::WORD_W-1:0] got,
                            input logic [mem_pkg::WORD_W-1:0] exp);
    if (got !== exp) begin
      word_errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // fetch line, lane 0 in the low word
  task automatic check_line(input string name,
                            input logic [mem_pkg::LINE_W-1:0] got,
                            input logic [mem_pkg::LINE_W-1:0] exp);
    if (got !== exp) begin
      line_errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_busy(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      busy_errors++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

`endif

// File: test/tb_dp_ram.sv
// tb_dp_ram
// Testbench for the dual-port memory: fills memory, runs directed cases
// from a file, checks busy and fetch collisions, then random traffic,
// all compared against a shadow model of the 256 words.

`timescale 1ns/1ps

module tb_dp_ram;

  logic                        clk_i = 1'b0;
  logic                        rst_i;
  mem_pkg::fetch_req_t         fetch_i;
  mem_pkg::data_req_t          data_i;
  logic [mem_pkg::LINE_W-1:0]  line_o;
  logic [mem_pkg::WORD_W-1:0]  rdata_o;
  logic                        busy_o;

  logic [mem_pkg::WORD_W-1:0]  shadow [2**mem_pkg::ADDR_W];  // expected memory contents
  logic [31:0]                 rng_state;

  `include "dp_ram_checks.svh"

  dp_ram_top dp_ram_top_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .fetch_i (fetch_i),
    .data_i  (data_i),
    .line_o  (line_o),
    .rdata_o (rdata_o),
    .busy_o  (busy_o)
  );

  always #5 clk_i = ~clk_i;  // 10 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // enabled bytes take the new data, the rest keep the old word
  function automatic logic [mem_pkg::WORD_W-1:0] merge_bytes(
    input logic [mem_pkg::WORD_W-1:0] old_w,
    input logic [mem_pkg::WORD_W-1:0] new_w,
    input logic [3:0]                 be
  );
    logic [mem_pkg::WORD_W-1:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (new_w & mask) | (old_w & ~mask);
  endfunction

  // row = addr / 4, lane 0 lowest
  function automatic logic [mem_pkg::LINE_W-1:0] expected_line(input logic [7:0] addr);
    return {shadow[{addr[7:2], 2'd3}], shadow[{addr[7:2], 2'd2}],
            shadow[{addr[7:2], 2'd1}], shadow[{addr[7:2], 2'd0}]};
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h3c, ~a, a, a ^ 8'ha5};  // every address bit shows up
  endfunction

  // called at a falling edge, returns at a falling edge with busy_o low
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < 8) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) begin
      other_errors++;
      $display("busy_o stayed high too long at t=%0t, gave up waiting", $time);
    end
  endtask

  task automatic do_write(input logic [7:0] addr, input logic [31:0] wdata,
                          input logic [3:0] be);
    wait_idle();
    data_i.en    = 1'b1;
    data_i.we    = 1'b1;
    data_i.be    = be;
    data_i.addr  = addr;
    data_i.wdata = wdata;
    @(posedge clk_i);
    @(negedge clk_i);
    data_i = '0;
    check_busy("busy_o", busy_o, 1'b1);  // merge cycle
    shadow[addr] = merge_bytes(shadow[addr], wdata, be);
    wait_idle();
  endtask

  // data read, optionally with a fetch on the same edge
  task automatic read_fetch(input logic [7:0] addr, input logic rd_en,
                            input logic [7:0] faddr, input logic f_en,
                            output logic [31:0] got_w, output logic [127:0] got_l);
    wait_idle();
    data_i.en    = rd_en;
    data_i.addr  = addr;
    fetch_i.en   = f_en;
    fetch_i.addr = faddr;
    @(posedge clk_i);
    @(negedge clk_i);
    data_i  = '0;
    fetch_i = '0;
    @(posedge clk_i);
    @(negedge clk_i);  // outputs stable here
    got_w = rdata_o;
    got_l = line_o;
  endtask

  task automatic run_cases();
    int             fd;
    int             code;
    logic [63:0]    op_tok;
    logic [1023:0]  rest;
    logic [7:0]     c_addr;
    logic [31:0]    c_wdata;
    logic [3:0]     c_be;
    logic [127:0]   c_exp;
    logic [31:0]    got_w;
    logic [127:0]   got_l;
    fd = $fopen("test/dp_ram_cases.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the case file test/dp_ram_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        op_tok = '0;
        code = $fscanf(fd, "%s", op_tok);
        if (code != 1) break;
        if (op_tok[7:0] == "#") begin
          code = $fgets(rest, fd);  // comment line
        end else begin
          code = $fscanf(fd, "%h %h %h %h", c_addr, c_wdata, c_be, c_exp);
          if (code != 4) begin
            other_errors++;
            $display("case file line is malformed, stopped reading");
            break;
          end
          case (op_tok[7:0])
            "W": do_write(c_addr, c_wdata, c_be);
            "R": begin
              read_fetch(c_addr, 1'b1, 8'h00, 1'b0, got_w, got_l);
              check_word("rdata_o", got_w, c_exp[31:0]);
              check_word("rdata_o vs shadow", got_w, shadow[c_addr]);
            end
            "F": begin
              read_fetch(8'h00, 1'b0, c_addr, 1'b1, got_w, got_l);
              check_line("line_o", got_l, c_exp);
              check_line("line_o vs shadow", got_l, expected_line(c_addr));
            end
            default: begin
              other_errors++;
              $display("unknown opcode in case file");
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // a data write presented during busy_o must be dropped
  task automatic busy_ignore_test(input logic [7:0] addr_a, input logic [7:0] addr_b);
    logic [31:0]  got_w;
    logic [127:0] got_l;
    wait_idle();
    data_i.en    = 1'b1;
    data_i.we    = 1'b1;
    data_i.be    = 4'hf;
    data_i.addr  = addr_a;
    data_i.wdata = 32'h0f1e2d3c;
    @(posedge clk_i);
    @(negedge clk_i);
    check_busy("busy_o", busy_o, 1'b1);
    shadow[addr_a] = merge_bytes(shadow[addr_a], 32'h0f1e2d3c, 4'hf);
    data_i.addr  = addr_b;  // still strobing, should be ignored
    data_i.wdata = 32'hbadbad00;
    @(posedge clk_i);
    @(negedge clk_i);
    data_i = '0;
    check_busy("busy_o", busy_o, 1'b0);  // no second write started
    read_fetch(addr_b, 1'b1, 8'h00, 1'b0, got_w, got_l);
    check_word("rdata_o ignored write", got_w, shadow[addr_b]);
    read_fetch(addr_a, 1'b1, 8'h00, 1'b0, got_w, got_l);
    check_word("rdata_o", got_w, shadow[addr_a]);
  endtask

  // fetch on the merge edge sees the old line, two cycles later the new one
  task automatic collision_test(input logic [7:0] addr);
    logic [127:0] old_line;
    logic [31:0]  new_w;
    logic [31:0]  got_w;
    logic [127:0] got_l;
    old_line = expected_line(addr);
    new_w    = ~shadow[addr];
    wait_idle();
    data_i.en    = 1'b1;
    data_i.we    = 1'b1;
    data_i.be    = 4'hf;
    data_i.addr  = addr;
    data_i.wdata = new_w;
    @(posedge clk_i);
    @(negedge clk_i);
    data_i       = '0;
    check_busy("busy_o", busy_o, 1'b1);
    fetch_i.en   = 1'b1;  // same edge as the bank write
    fetch_i.addr = addr;
    @(posedge clk_i);
    @(negedge clk_i);
    fetch_i = '0;
    shadow[addr] = new_w;
    @(posedge clk_i);
    @(negedge clk_i);
    check_line("line_o collision", line_o, old_line);
    read_fetch(8'h00, 1'b0, addr, 1'b1, got_w, got_l);
    check_line("line_o after write", got_l, expected_line(addr));
  endtask

  task automatic random_ops(input int count);
    logic [31:0]  r;
    logic [31:0]  wd;
    logic [31:0]  got_w;
    logic [127:0] got_l;
    for (int i = 0; i < count; i++) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      case (r[9:8])
        2'd0: begin  // read with a concurrent fetch
          read_fetch(r[7:0], 1'b1, r[17:10], 1'b1, got_w, got_l);
          check_word("rdata_o", got_w, shadow[r[7:0]]);
          check_line("line_o", got_l, expected_line(r[17:10]));
        end
        2'd1: begin
          read_fetch(r[7:0], 1'b1, 8'h00, 1'b0, got_w, got_l);
          check_word("rdata_o", got_w, shadow[r[7:0]]);
        end
        default: begin
          rng_state = xorshift32(rng_state);
          wd = rng_state;
          do_write(r[7:0], wd, r[13:10]);
        end
      endcase
    end
  endtask

  initial begin
    int total;
    rst_i     = 1'b1;
    fetch_i   = '0;
    data_i    = '0;
    rng_state = 32'd76296;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_busy("busy_o after reset", busy_o, 1'b0);
    check_line("line_o after reset", line_o, '0);
    check_word("rdata_o after reset", rdata_o, '0);

    for (int a = 0; a < 256; a++) begin
      do_write(a[7:0], fill_word(a[7:0]), 4'hf);  // known contents everywhere
    end
    run_cases();
    busy_ignore_test(8'h41, 8'h42);
    collision_test(8'h85);
    random_ops(200);

    total = word_errors + line_errors + busy_errors + other_errors;
    $display("errors: word %0d line %0d busy %0d other %0d",
             word_errors, line_errors, busy_errors, other_errors);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: test/dp_ram_cases.txt
# op addr wdata be expect (expect is the word for R, the line for F, unused for W)
# fetch lines list lane 3 first, lane 0 is the low word
W 10 11111111 f 0
R 10 00000000 0 11111111
W 11 22222222 f 0
W 12 33333333 f 0
W 13 44444444 f 0
R 13 00000000 0 44444444
F 10 00000000 0 44444444333333332222222211111111
F 11 00000000 0 44444444333333332222222211111111
F 12 00000000 0 44444444333333332222222211111111
F 13 00000000 0 44444444333333332222222211111111
W 20 a5a5a5a5 f 0
W 20 12345678 5 0
R 20 00000000 0 a534a578
W 20 deadbeef 8 0
R 20 00000000 0 de34a578
W 21 ffffffff f 0
W 21 00000000 3 0
R 21 00000000 0 ffff0000
W 21 12345678 0 0
R 21 00000000 0 ffff0000
W 22 00000000 f 0
W 22 cafef00d 6 0
R 22 00000000 0 00fef000
W 23 89abcdef f 0
F 22 00000000 0 89abcdef00fef000ffff0000de34a578
W fc 01020304 f 0
W fd 05060708 f 0
W fe 090a0b0c f 0
W ff 0badc0de f 0
F fd 00000000 0 0badc0de090a0b0c0506070801020304

// File: verilog.f
+incdir+test
src/mem_pkg.sv
src/ram_bank.sv
src/bank_router.sv
src/line_collector.sv
src/dp_ram_top.sv
test/tb_dp_ram.sv

// File: Makefile
# Verilator build and run for the dual-port memory testbench

TOP = tb_dp_ram

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP) -Mdir obj_dir

# pass only if the pass message shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
